// ==== testbench/fpPost_testdata.txt ====
// columns: src (0 mul, 1 cvt), operand a or integer, operand b, rounding mode, result, flags
// flags: invalid overflow underflow inexact, high bit first
// multiply, exact and rounded
0 3C00 3C00 0 3C00 0
0 3E00 4000 0 4200 0
0 3C01 3C01 0 3C02 1
0 3C01 3C01 3 3C03 1
0 BC01 3C01 2 BC03 1
0 BC01 3C01 3 BC02 1
// ties, to even and to max magnitude
0 3E00 3C01 0 3E02 1
0 3E00 3C03 0 3E04 1
0 3E00 3C03 4 3E05 1
// overflow by mode
0 7BFF 7BFF 0 7C00 5
0 7BFF 7BFF 1 7BFF 5
0 FBFF 7BFF 3 FBFF 5
0 FBFF 7BFF 2 FC00 5
// flush to zero and smallest normal
0 0400 3800 0 0000 3
0 8400 3800 1 8000 3
0 0400 3C00 0 0400 0
// special operands
0 7E00 3C00 0 7E00 0
0 7C01 3C00 0 7E00 8
0 7C00 0000 0 7E00 8
0 FC00 4000 0 FC00 0
0 8001 3C00 0 8000 0
// integer convert
1 0000 0000 0 0000 0
1 8000 0000 0 F800 0
1 07FF 0000 0 67FF 0
1 07FF 0000 2 67FF 0
1 0801 0000 0 6800 1
1 0801 0000 3 6801 1
1 0801 0000 4 6801 1
1 F7FF 0000 2 E801 1
1 7FFF 0000 0 7800 1
1 7FFF 0000 1 77FF 1
1 8001 0000 2 F800 1
1 8001 0000 1 F7FF 1
1 FFFF 0000 0 BC00 0

// ==== build.f ====
verilog/fpFormatPkg.sv
verilog/fpUnitPkg.sv
verilog/fpMultiply.sv
verilog/intConvert.sv
verilog/postArbiter.sv
verilog/postprocess.sv
verilog/resultCredit.sv
verilog/fpPostTop.sv
testbench/tbFpPost.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tbFpPost
FILELIST = build.f
BUILDDIR = obj_dir
SIMBIN   = $(BUILDDIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: $(SIMBIN)
	./$(SIMBIN) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// ==== testbench/tbFpPost.sv ====
// testbench for the half-precision post-processing subsystem driven from a data file
`timescale 1ns/10ps

module tbFpPost;

    localparam int fieldsPerRecord = 6;     // src, a, b, rm, result, flags
    localparam int maxRecords      = 64;
    localparam int waitLimit       = 2000;  // cycles allowed for any single wait

    logic clk;
    logic reset;
    logic mulValid;
    fpFormatPkg::halfT mulA, mulB;
    fpUnitPkg::rmT mulRm;
    logic mulCredit;
    logic cvtValid;
    logic signed [15:0] cvtInt;
    fpUnitPkg::rmT cvtRm;
    logic cvtCredit;
    logic resValid;
    fpFormatPkg::halfT resValue;
    fpUnitPkg::flagT resFlags;
    fpUnitPkg::srcT resSrc;
    logic resCredit = 1'b0;

    logic [15:0] testMem [0:fieldsPerRecord*maxRecords-1];
    int mulList[$];                  // record base per source in send order
    int cvtList[$];
    int mulSent, cvtSent, mulRecv, cvtRecv;
    int mulHeld, cvtHeld;            // input credits held by each source
    int mulCreditCount, cvtCreditCount;
    int outstanding;                 // results not yet credited back
    int cycle = 0;
    int creditDue[$];                // cycle at which each output credit goes back
    logic mulValidLast = 1'b0;
    logic cvtValidLast = 1'b0;
    logic mulFull = 1'b0;            // mirror of each front end slot
    logic cvtFull = 1'b0;
    logic fairPending = 1'b0;        // other side waited at the last issue
    fpUnitPkg::srcT fairNext;

    fpPostTop u_fpPostTop (.clk, .reset, .mulValid, .mulA, .mulB, .mulRm, .mulCredit,
        .cvtValid, .cvtInt, .cvtRm, .cvtCredit, .resValid, .resValue, .resFlags, .resSrc,
        .resCredit);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;      // 20 ns period
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] want);
        if (got !== want)
            abortRun($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                               $time, name, got, want));
    endtask

    task automatic loadTestData();
        // any src value above 1 marks the end of the data
        for (int i = 0; i < fieldsPerRecord*maxRecords; i++)
            testMem[i] = 16'h8000 | 16'(i);
        $readmemh("testbench/fpPost_testdata.txt", testMem);
        for (int r = 0; r < maxRecords; r++) begin
            if (testMem[r*fieldsPerRecord] > 16'd1) break;
            if (testMem[r*fieldsPerRecord] == 16'd0) mulList.push_back(r*fieldsPerRecord);
            else cvtList.push_back(r*fieldsPerRecord);
        end
        if (mulList.size() == 0 || cvtList.size() == 0)
            abortRun("the test data holds no records for one of the sources");
    endtask

    // one source sends one valid pulse per record after a random gap and its credit
    task automatic driveRecords(input logic toCvt);
        int total;
        int base;
        int waited;
        total = toCvt ? cvtList.size() : mulList.size();
        for (int k = 0; k < total; k++) begin
            base = toCvt ? cvtList[k] : mulList[k];
            repeat ($urandom_range(4, 0)) @(posedge clk);   // idle gap
            waited = 0;
            while ((toCvt ? cvtHeld : mulHeld) == 0) begin
                @(posedge clk);
                waited++;
                if (waited > waitLimit) begin
                    if (toCvt) abortRun("timeout waiting for cvtCredit");
                    else abortRun("timeout waiting for mulCredit");
                end
            end
            if (toCvt) begin
                cvtValid <= 1'b1;
                cvtInt   <= testMem[base + 1];
                cvtRm    <= testMem[base + 3][2:0];
                cvtHeld--;
                cvtSent++;
            end else begin
                mulValid <= 1'b1;
                mulA     <= testMem[base + 1];
                mulB     <= testMem[base + 2];
                mulRm    <= testMem[base + 3][2:0];
                mulHeld--;
                mulSent++;
            end
            @(posedge clk);
            if (toCvt) cvtValid <= 1'b0;
            else mulValid <= 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // monitor sampling at the falling edge
    ////////////////////////////////////////

    always @(negedge clk) begin : monitor
        int base;
        if (!reset) begin
            if (mulCredit) begin
                mulHeld++;
                mulCreditCount++;
            end
            if (cvtCredit) begin
                cvtHeld++;
                cvtCreditCount++;
            end
            if (mulHeld > 1 || cvtHeld > 1)
                abortRun("an input credit came back with no input accepted");
            if (resCredit) outstanding--;
            if (resValid) begin
                if (mulSent + cvtSent == 0)
                    abortRun("a result appeared before any input was sent");
                // a front end left waiting is served next
                if (fairPending) checkValue("resSrc turn", 16'(resSrc), 16'(fairNext));
                fairPending = (resSrc == fpUnitPkg::srcCvt) ? mulFull : cvtFull;
                fairNext    = ~resSrc;
                if (resSrc == fpUnitPkg::srcCvt) begin
                    if (cvtRecv >= cvtSent)
                        abortRun("a convert result came with no convert input pending");
                    base = cvtList[cvtRecv];
                    cvtRecv++;
                end else begin
                    if (mulRecv >= mulSent)
                        abortRun("a multiply result came with no multiply input pending");
                    base = mulList[mulRecv];
                    mulRecv++;
                end
                checkValue("resValue", resValue, testMem[base + 4]);
                checkValue("resFlags", 16'(resFlags), testMem[base + 5]);
                outstanding++;
                if (outstanding > fpUnitPkg::resultCredits)
                    abortRun("more results outstanding than output credits");
                creditDue.push_back(cycle + int'($urandom_range(6, 0)));
            end
            // slot full from the cycle after valid until its credit shows
            mulFull      = mulValidLast | (mulFull & ~mulCredit);
            cvtFull      = cvtValidLast | (cvtFull & ~cvtCredit);
            mulValidLast = mulValid;
            cvtValidLast = cvtValid;
        end
    end

    // downstream buffer frees entries after a random delay
    always @(posedge clk) begin
        cycle++;
        if (!reset && creditDue.size() > 0 && creditDue[0] <= cycle) begin
            creditDue.delete(0);
            resCredit <= 1'b1;
        end else begin
            resCredit <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int waited;
        void'($urandom(9993));
        reset     = 1'b1;
        mulValid  = 1'b0;
        mulA      = '0;
        mulB      = '0;
        mulRm     = '0;
        cvtValid  = 1'b0;
        cvtInt    = '0;
        cvtRm     = '0;
        mulHeld   = 1;               // one slot each
        cvtHeld   = 1;
        loadTestData();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        fork
            driveRecords(1'b0);
            driveRecords(1'b1);
        join
        waited = 0;
        while (mulRecv < mulList.size() || cvtRecv < cvtList.size()) begin
            @(posedge clk);
            waited++;
            if (waited > waitLimit) abortRun("timeout waiting for all results");
        end
        waited = 0;
        while (outstanding != 0) begin
            @(posedge clk);
            waited++;
            if (waited > waitLimit) abortRun("timeout waiting for the output credits to come back");
        end
        checkValue("mulCredit pulses", 16'(mulCreditCount), 16'(mulList.size()));
        checkValue("cvtCredit pulses", 16'(cvtCreditCount), 16'(cvtList.size()));
        $display("Test OK");
        $finish;
    end

endmodule

// ==== verilog/fpPostTop.sv ====
// half-precision post-processing subsystem: two front ends sharing one round and flag unit
`timescale 1ns/10ps

module fpPostTop (
    input  logic               clk,
    input  logic               reset,
    input  logic               mulValid,
    input  fpFormatPkg::halfT  mulA,
    input  fpFormatPkg::halfT  mulB,
    input  fpUnitPkg::rmT      mulRm,
    output logic               mulCredit,
    input  logic               cvtValid,
    input  logic signed [15:0] cvtInt,
    input  fpUnitPkg::rmT      cvtRm,
    output logic               cvtCredit,
    output logic               resValid,
    output fpFormatPkg::halfT  resValue,
    output fpUnitPkg::flagT    resFlags,
    output fpUnitPkg::srcT     resSrc,
    input  logic               resCredit
);

    // front end fields
    logic mulReq, mulGrant, mulSign, mulSticky, mulIsNaN, mulIsInf, mulIsZero, mulIsInvalid;
    logic cvtReq, cvtGrant, cvtSign, cvtSticky, cvtIsNaN, cvtIsInf, cvtIsZero, cvtIsInvalid;
    fpFormatPkg::expT mulExp, cvtExp;
    fpFormatPkg::wideManT mulMan, cvtMan;
    fpUnitPkg::rmT mulRmSlot, cvtRmSlot;

    // shared post-processor bus
    logic sign, sticky, isNaN, isInf, isZero, isInvalid, issue, room;
    fpFormatPkg::expT exp;
    fpFormatPkg::wideManT man;
    fpUnitPkg::rmT rm;
    fpUnitPkg::srcT src;

    fpMultiply u_fpMultiply (.clk, .reset, .mulValid, .mulA, .mulB, .mulRm, .grant(mulGrant),
        .request(mulReq), .sign(mulSign), .exp(mulExp), .man(mulMan), .sticky(mulSticky),
        .rm(mulRmSlot), .isNaN(mulIsNaN), .isInf(mulIsInf), .isZero(mulIsZero),
        .isInvalid(mulIsInvalid), .mulCredit);

    intConvert u_intConvert (.clk, .reset, .cvtValid, .cvtInt, .cvtRm, .grant(cvtGrant),
        .request(cvtReq), .sign(cvtSign), .exp(cvtExp), .man(cvtMan), .sticky(cvtSticky),
        .rm(cvtRmSlot), .isNaN(cvtIsNaN), .isInf(cvtIsInf), .isZero(cvtIsZero),
        .isInvalid(cvtIsInvalid), .cvtCredit);

    postArbiter u_postArbiter (.clk, .reset, .mulReq, .cvtReq, .room, .mulGrant, .cvtGrant,
        .mulSign, .mulExp, .mulMan, .mulSticky, .mulRm(mulRmSlot), .mulIsNaN, .mulIsInf,
        .mulIsZero, .mulIsInvalid, .cvtSign, .cvtExp, .cvtMan, .cvtSticky, .cvtRm(cvtRmSlot),
        .cvtIsNaN, .cvtIsInf, .cvtIsZero, .cvtIsInvalid, .sign, .exp, .man, .sticky, .rm,
        .isNaN, .isInf, .isZero, .isInvalid, .src, .issue);

    postprocess u_postprocess (.clk, .reset, .issue, .src, .sign, .exp, .man, .sticky, .rm,
        .isNaN, .isInf, .isZero, .isInvalid, .resValid, .resValue, .resFlags, .resSrc);

    resultCredit u_resultCredit (.clk, .reset, .issue, .resCredit, .room);

endmodule

// ==== verilog/resultCredit.sv ====
// output credit counter: allows an issue only while the result buffer has room
`timescale 1ns/10ps

module resultCredit (
    input  logic clk,
    input  logic reset,
    input  logic issue,       // one result on its way out
    input  logic resCredit,   // downstream freed one entry
    output logic room
);

    logic [$clog2(fpUnitPkg::resultCredits + 1)-1:0] count;

    // issue and return may land in the same cycle and cancel
    always_ff @(posedge clk) begin
        if (reset) count <= ($bits(count))'(fpUnitPkg::resultCredits);
        else if (issue && !resCredit) count <= count - 1'b1;
        else if (resCredit && !issue) count <= count + 1'b1;
    end

    assign room = (count != '0);

    noCreditUnderflow: assert property (@(posedge clk) disable iff (reset)
        issue |-> (count != '0))
        else $error("result issued with no output credit");

    noCreditOverflow: assert property (@(posedge clk) disable iff (reset)
        (resCredit && !issue) |-> (count < fpUnitPkg::resultCredits))
        else $error("more output credits returned than issued");

endmodule

// ==== verilog/postprocess.sv ====
// shared post-processor: normalize, round, special results and flags, one register stage
`timescale 1ns/10ps

module postprocess (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 issue,
    input  fpUnitPkg::srcT       src,
    input  logic                 sign,
    input  fpFormatPkg::expT     exp,
    input  fpFormatPkg::wideManT man,        // value is man[21].man[20:0] * 2^(exp-bias)
    input  logic                 sticky,
    input  fpUnitPkg::rmT        rm,
    input  logic                 isNaN,
    input  logic                 isInf,
    input  logic                 isZero,
    input  logic                 isInvalid,
    output logic                 resValid,
    output fpFormatPkg::halfT    resValue,
    output fpUnitPkg::flagT      resFlags,
    output fpUnitPkg::srcT       resSrc
);

    fpFormatPkg::shiftT shift;
    fpFormatPkg::wideManT normMan;
    fpFormatPkg::expT normExp, roundExp;
    logic lsb, rndBit, stk;
    logic roundUp, ovfToInf;
    logic [11:0] sum;                        // hidden bit, fraction and carry out
    logic tiny, overflow, inexact;
    fpFormatPkg::halfT resultNext;
    fpUnitPkg::flagT flagsNext;

    ////////////////////////////////////////
    // normalization
    ////////////////////////////////////////

    always_comb begin
        shift = '0;
        for (int i = 0; i < 22; i++)
            if (man[i]) shift = fpFormatPkg::shiftT'(21 - i);
    end

    assign normMan = man << shift;
    assign normExp = exp - fpFormatPkg::expT'(shift);

    ////////////////////////////////////////
    // rounding
    ////////////////////////////////////////

    assign lsb     = normMan[11];            // last kept fraction bit
    assign rndBit  = normMan[10];
    assign stk     = (|normMan[9:0]) | sticky;
    assign inexact = rndBit | stk;

    always_comb begin
        case (rm)
            fpUnitPkg::rmNearEven:   roundUp = rndBit & (stk | lsb);
            fpUnitPkg::rmTowardZero: roundUp = 1'b0;
            fpUnitPkg::rmDown:       roundUp = sign & inexact;
            fpUnitPkg::rmUp:         roundUp = ~sign & inexact;
            fpUnitPkg::rmNearMax:    roundUp = rndBit;
            default:                 roundUp = 1'b0;
        endcase
    end

    // carry out leaves a zero fraction, so only the exponent moves
    assign sum      = {1'b0, normMan[21:11]} + 12'(roundUp);
    assign roundExp = normExp + fpFormatPkg::expT'(sum[11]);

    // tininess before rounding, flushed to zero
    assign tiny     = $signed(normExp) < 1;
    assign overflow = $signed(roundExp) >= fpFormatPkg::expMax;

    always_comb begin
        case (rm)
            fpUnitPkg::rmTowardZero: ovfToInf = 1'b0;
            fpUnitPkg::rmDown:       ovfToInf = sign;
            fpUnitPkg::rmUp:         ovfToInf = ~sign;
            default:                 ovfToInf = 1'b1;  // nearest modes
        endcase
    end

    ////////////////////////////////////////
    // result and flag select
    ////////////////////////////////////////

    always_comb begin
        flagsNext = '0;
        if (isInvalid | isNaN) begin
            resultNext = fpFormatPkg::quietNaN;
            flagsNext[fpUnitPkg::flagInvalid] = isInvalid;
        end else if (isInf) begin
            resultNext = {sign, 5'(fpFormatPkg::expMax), 10'b0};
        end else if (isZero) begin
            resultNext = {sign, 15'b0};      // keeps the sign
        end else if (tiny) begin
            resultNext = {sign, 15'b0};
            flagsNext[fpUnitPkg::flagUnderflow] = 1'b1;
            flagsNext[fpUnitPkg::flagInexact]   = 1'b1;
        end else if (overflow) begin
            if (ovfToInf) resultNext = {sign, 5'(fpFormatPkg::expMax), 10'b0};
            else resultNext = {sign, 5'(fpFormatPkg::expMax - 1),
                               {fpFormatPkg::fracWidth{1'b1}}};  // largest finite
            flagsNext[fpUnitPkg::flagOverflow] = 1'b1;
            flagsNext[fpUnitPkg::flagInexact]  = 1'b1;
        end else begin
            resultNext = {sign, roundExp[4:0], sum[fpFormatPkg::fracWidth-1:0]};
            flagsNext[fpUnitPkg::flagInexact] = inexact;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) resValid <= 1'b0;
        else resValid <= issue;
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            resValue <= resultNext;
            resFlags <= flagsNext;
            resSrc   <= src;
        end
    end

endmodule

// ==== verilog/postArbiter.sv ====
// round-robin arbiter that hands the shared post-processor to one front end per cycle
`timescale 1ns/10ps

module postArbiter (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 mulReq,
    input  logic                 cvtReq,
    input  logic                 room,        // an output credit is available
    output logic                 mulGrant,
    output logic                 cvtGrant,
    input  logic                 mulSign,
    input  fpFormatPkg::expT     mulExp,
    input  fpFormatPkg::wideManT mulMan,
    input  logic                 mulSticky,
    input  fpUnitPkg::rmT        mulRm,
    input  logic                 mulIsNaN,
    input  logic                 mulIsInf,
    input  logic                 mulIsZero,
    input  logic                 mulIsInvalid,
    input  logic                 cvtSign,
    input  fpFormatPkg::expT     cvtExp,
    input  fpFormatPkg::wideManT cvtMan,
    input  logic                 cvtSticky,
    input  fpUnitPkg::rmT        cvtRm,
    input  logic                 cvtIsNaN,
    input  logic                 cvtIsInf,
    input  logic                 cvtIsZero,
    input  logic                 cvtIsInvalid,
    output logic                 sign,
    output fpFormatPkg::expT     exp,
    output fpFormatPkg::wideManT man,
    output logic                 sticky,
    output fpUnitPkg::rmT        rm,
    output logic                 isNaN,
    output logic                 isInf,
    output logic                 isZero,
    output logic                 isInvalid,
    output fpUnitPkg::srcT       src,
    output logic                 issue
);

    fpUnitPkg::arbStateT state;
    logic pickCvt;

    // convert wins when alone or when it is its turn
    assign pickCvt  = cvtReq & (~mulReq | (state == fpUnitPkg::preferCvt));
    assign mulGrant = room & mulReq & ~pickCvt;
    assign cvtGrant = room & pickCvt;
    assign issue    = mulGrant | cvtGrant;
    assign src      = pickCvt ? fpUnitPkg::srcCvt : fpUnitPkg::srcMul;

    // shared bus follows the pick
    assign sign      = pickCvt ? cvtSign      : mulSign;
    assign exp       = pickCvt ? cvtExp       : mulExp;
    assign man       = pickCvt ? cvtMan       : mulMan;
    assign sticky    = pickCvt ? cvtSticky    : mulSticky;
    assign rm        = pickCvt ? cvtRm        : mulRm;
    assign isNaN     = pickCvt ? cvtIsNaN     : mulIsNaN;
    assign isInf     = pickCvt ? cvtIsInf     : mulIsInf;
    assign isZero    = pickCvt ? cvtIsZero    : mulIsZero;
    assign isInvalid = pickCvt ? cvtIsInvalid : mulIsInvalid;

    always_ff @(posedge clk) begin
        if (reset) state <= fpUnitPkg::preferMul;
        else if (mulGrant) state <= fpUnitPkg::preferCvt;
        else if (cvtGrant) state <= fpUnitPkg::preferMul;
    end

    grantOneWithRoom: assert property (@(posedge clk) disable iff (reset)
        (mulGrant || cvtGrant) |-> (room && !(mulGrant && cvtGrant)))
        else $error("grant without room or double grant");

endmodule

// ==== verilog/intConvert.sv ====
// convert front end: holds one signed integer and forms sign, left-aligned magnitude and exponent
`timescale 1ns/10ps

module intConvert (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cvtValid,
    input  logic signed [15:0]   cvtInt,
    input  fpUnitPkg::rmT        cvtRm,
    input  logic                 grant,
    output logic                 request,
    output logic                 sign,
    output fpFormatPkg::expT     exp,
    output fpFormatPkg::wideManT man,
    output logic                 sticky,
    output fpUnitPkg::rmT        rm,
    output logic                 isNaN,
    output logic                 isInf,
    output logic                 isZero,
    output logic                 isInvalid,
    output logic                 cvtCredit
);

    logic signed [15:0] intReg;
    logic full;
    logic [15:0] mag;                       // -32768 comes out as 16'h8000
    logic [15:0] aligned;
    fpFormatPkg::shiftT lzc;

    always_ff @(posedge clk) begin
        if (reset) begin
            full      <= 1'b0;
            cvtCredit <= 1'b0;
        end else begin
            cvtCredit <= grant;
            if (cvtValid) full <= 1'b1;
            else if (grant) full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cvtValid) begin
            intReg <= cvtInt;
            rm     <= cvtRm;
        end
    end

    assign mag = intReg[15] ? 16'(-intReg) : 16'(intReg);

    // leading-zero count, highest set bit wins
    always_comb begin
        lzc = '0;
        for (int i = 0; i < 16; i++)
            if (mag[i]) lzc = fpFormatPkg::shiftT'(15 - i);
    end

    assign aligned = mag << lzc;

    assign request   = full;
    assign sign      = intReg[15];
    assign man       = {aligned, 6'b0};     // leading one lands in bit 21
    assign exp       = fpFormatPkg::expT'(fpFormatPkg::bias + 15 - int'(lzc));
    assign sticky    = 1'b0;
    assign isZero    = (mag == '0);
    assign isNaN     = 1'b0;                // integers have no special values
    assign isInf     = 1'b0;
    assign isInvalid = 1'b0;

    slotNoOverrun: assert property (@(posedge clk) disable iff (reset) cvtValid |-> !full)
        else $error("integer operand arrived while the slot was full");

endmodule

// ==== verilog/fpMultiply.sv ====
// multiply front end: holds one operand pair, classifies it and forms the exact product
`timescale 1ns/10ps

module fpMultiply (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 mulValid,    // source pulses while holding its credit
    input  fpFormatPkg::halfT    mulA,
    input  fpFormatPkg::halfT    mulB,
    input  fpUnitPkg::rmT        mulRm,
    input  logic                 grant,       // post-processor takes the slot
    output logic                 request,
    output logic                 sign,
    output fpFormatPkg::expT     exp,
    output fpFormatPkg::wideManT man,
    output logic                 sticky,
    output fpUnitPkg::rmT        rm,
    output logic                 isNaN,
    output logic                 isInf,
    output logic                 isZero,
    output logic                 isInvalid,
    output logic                 mulCredit    // credit back to the source
);

    fpFormatPkg::halfT aReg, bReg;
    logic full;
    logic [fpFormatPkg::expWidth-1:0] aExp, bExp;
    logic [fpFormatPkg::fracWidth-1:0] aFrac, bFrac;
    fpFormatPkg::manT aMan, bMan;
    logic aZero, bZero, aInf, bInf, aNaN, bNaN;

    // slot state and credit return
    always_ff @(posedge clk) begin
        if (reset) begin
            full      <= 1'b0;
            mulCredit <= 1'b0;
        end else begin
            mulCredit <= grant;             // high in the cycle the slot is empty again
            if (mulValid) full <= 1'b1;
            else if (grant) full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (mulValid) begin
            aReg <= mulA;
            bReg <= mulB;
            rm   <= mulRm;
        end
    end

    assign aExp  = aReg[fpFormatPkg::fracWidth +: fpFormatPkg::expWidth];
    assign bExp  = bReg[fpFormatPkg::fracWidth +: fpFormatPkg::expWidth];
    assign aFrac = aReg[fpFormatPkg::fracWidth-1:0];
    assign bFrac = bReg[fpFormatPkg::fracWidth-1:0];

    // subnormal operands count as zero
    assign aZero = (aExp == '0);
    assign bZero = (bExp == '0);
    assign aInf  = (aExp == fpFormatPkg::expMax) && (aFrac == '0);
    assign bInf  = (bExp == fpFormatPkg::expMax) && (bFrac == '0);
    assign aNaN  = (aExp == fpFormatPkg::expMax) && (aFrac != '0);
    assign bNaN  = (bExp == fpFormatPkg::expMax) && (bFrac != '0);

    assign request   = full;
    assign sign      = aReg[15] ^ bReg[15];
    assign isNaN     = aNaN | bNaN;
    assign isInf     = aInf | bInf;
    assign isZero    = aZero | bZero;
    // signaling NaN has the quiet bit clear
    assign isInvalid = (aNaN & ~aFrac[9]) | (bNaN & ~bFrac[9]) | (aInf & bZero) | (aZero & bInf);

    assign aMan   = {1'b1, aFrac};
    assign bMan   = {1'b1, bFrac};
    assign man    = aMan * bMan;            // exact, two integer bits
    assign sticky = 1'b0;                   // nothing dropped
    // +1 puts the binary point after the top product bit
    assign exp = fpFormatPkg::expT'(int'(aExp) + int'(bExp) - fpFormatPkg::bias + 1);

    slotNoOverrun: assert property (@(posedge clk) disable iff (reset) mulValid |-> !full)
        else $error("multiply operand arrived while the slot was full");

endmodule

// ==== verilog/fpUnitPkg.sv ====
// post-processing unit control: rounding modes, source tags, flags, credits, arbiter states
package fpUnitPkg;

    // IEEE rounding-mode encoding, as in the frm field
    typedef logic [2:0] rmT;
    localparam rmT rmNearEven   = 3'd0;
    localparam rmT rmTowardZero = 3'd1;
    localparam rmT rmDown       = 3'd2;   // toward -inf
    localparam rmT rmUp         = 3'd3;   // toward +inf
    localparam rmT rmNearMax    = 3'd4;   // ties away from zero

    // which front end a result came from
    typedef logic srcT;
    localparam srcT srcMul = 1'b0;
    localparam srcT srcCvt = 1'b1;

    // exception flags, invalid in the top bit
    typedef logic [3:0] flagT;
    localparam int flagInvalid   = 3;
    localparam int flagOverflow  = 2;
    localparam int flagUnderflow = 1;
    localparam int flagInexact   = 0;

    localparam int resultCredits = 4;   // downstream result buffer depth

    // round-robin pointer for the shared post-processor
    typedef enum logic {preferMul, preferCvt} arbStateT;

endpackage

// ==== verilog/fpFormatPkg.sv ====
// binary16 number format: field widths, exponent limits and field types
package fpFormatPkg;

    ////////////////////////////////////////
    // field geometry
    ////////////////////////////////////////

    localparam int expWidth  = 5;    // biased exponent bits
    localparam int fracWidth = 10;   // stored fraction bits
    localparam int bias      = 15;
    localparam int expMax    = 31;   // all-ones exponent, inf and NaN

    ////////////////////////////////////////
    // field types
    ////////////////////////////////////////

    // packed sign, exponent, fraction
    typedef logic [15:0] halfT;

    // biased exponent with two extra bits for sign and overflow,
    // read as two's complement wherever range is checked
    typedef logic [6:0] expT;

    typedef logic [10:0] manT;       // hidden bit plus fraction
    typedef logic [21:0] wideManT;   // unnormalized, point after the top bit
    typedef logic [4:0] shiftT;      // normalization shift, 0 to 21

    // canonical quiet NaN, positive, top fraction bit set
    localparam halfT quietNaN = 16'h7E00;

endpackage
